//--- hw/iso14443a_params.svh
// ISO 14443 type A receive path parameters
// byte width, output bit-count width and frame limits shared by the RTL and testbench

`ifndef ISO14443A_PARAMS_SVH
`define ISO14443A_PARAMS_SVH

// data bits per byte, sent lsb first
`define ISO_BYTE_BITS 8
// width of the data_bits output, enough for a short byte of 1 to 7 bits
`define ISO_BITCNT_W 3
// bits on air per byte, the data bits followed by one odd parity bit
`define ISO_FRAME_BITS 9
// consecutive Y sequences after which the sampler drops alignment
`define ISO_IDLE_Y_LIMIT 2

`endif

//--- hw/iso14443a_pkg.sv
// ISO 14443 type A receive path types
// Miller sequence codes and the frame state shared by the decode stages

package iso14443a_pkg;

    // a sequence is the pair {pause in first half, pause in second half}
    // so the sampler can build it straight from the two half-bit samples
    typedef enum logic [1:0] {
        SEQ_Y   = 2'b00,
        SEQ_X   = 2'b01,
        SEQ_Z   = 2'b10,
        SEQ_BAD = 2'b11
    } miller_seq_t;

    // frame tracking state of the decoder and the byte assembler
    // RX_ERROR means the rest of the frame is ignored until the next start
    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,
        RX_FRAME = 2'b01,
        RX_ERROR = 2'b10
    } rx_state_t;

endpackage

//--- hw/bit_stream_if.sv
// Decoded bit stream link between the Miller bit decoder and the byte assembler
// a beat is one cycle with valid high and carries exactly one of
// soc, eoc, seq_error or a plain data bit in bit_value

`timescale 1ns/1ps

interface bit_stream_if;

    logic valid;
    logic bit_value;
    logic soc;
    logic eoc;
    logic seq_error;

    // the decoder drives the stream
    modport source (output valid, bit_value, soc, eoc, seq_error);

    // the assembler takes every beat, there is no back-pressure
    modport sink (input valid, bit_value, soc, eoc, seq_error);

endinterface

//--- hw/miller_sequence_sampler.sv
// Miller sequence sampler, stage 1 of the ISO 14443 type A receive path
// pairs half-bit pause samples into X, Y and Z sequences and keeps half-bit
// alignment, dropping it after an idle run or a both-halves pause

`timescale 1ns/1ps

module miller_sequence_sampler
    import iso14443a_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sample_valid,
    input  logic        pause,
    output logic        seq_valid,
    output miller_seq_t seq
);

`include "iso14443a_params.svh"

    logic        aligned;
    logic        second_half;
    logic        first_pause;
    logic [1:0]  y_count;
    miller_seq_t seq_next;

    // the first half is held in first_pause, the current sample is the second half
    assign seq_next = miller_seq_t'({first_pause, pause});

    // ==================================================
    // alignment and phase control
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aligned     <= 1'b0;
            second_half <= 1'b0;
            y_count     <= 2'd0;
            seq_valid   <= 1'b0;
        end else begin
            seq_valid <= 1'b0;
            if (sample_valid) begin
                if (!aligned) begin
                    // a frame opens with Z, so the first pause seen is a first half
                    if (pause) begin
                        aligned     <= 1'b1;
                        second_half <= 1'b1;
                    end
                end else if (!second_half) begin
                    second_half <= 1'b1;
                end else begin
                    second_half <= 1'b0;
                    seq_valid   <= 1'b1;
                    if (seq_next == SEQ_BAD) begin
                        aligned <= 1'b0;
                        y_count <= 2'd0;
                    end else if (seq_next == SEQ_Y) begin
                        // Y Y cannot occur inside a frame, so the frame is over
                        if (y_count == 2'(`ISO_IDLE_Y_LIMIT - 1)) begin
                            aligned <= 1'b0;
                            y_count <= 2'd0;
                        end else begin
                            y_count <= y_count + 2'd1;
                        end
                    end else begin
                        y_count <= 2'd0;
                    end
                end
            end
        end
    end

    // sequence payload, only looked at while seq_valid is high
    always_ff @(posedge clk) begin
        if (sample_valid && !second_half) begin
            first_pause <= pause;
        end
        if (sample_valid && aligned && second_half) begin
            seq <= seq_next;
        end
    end

endmodule

//--- hw/miller_bit_decoder.sv
// Miller bit decoder, stage 2 of the ISO 14443 type A receive path
// applies the modified Miller rules to the sequence stream and emits start,
// data bits, end and sequence errors on the bit stream interface
// each bit is held until the next sequence shows it is not the end marker

`timescale 1ns/1ps

module miller_bit_decoder
    import iso14443a_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         seq_valid,
    input  miller_seq_t  seq,
    bit_stream_if.source bits
);

    rx_state_t state;

    // logic value of the last sequence, also the value of the held bit
    logic prev_bit;
    // the held bit is data and not the start marker
    logic held_valid;

    // ==================================================
    // sequence to bit decoding
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= RX_IDLE;
            prev_bit       <= 1'b0;
            held_valid     <= 1'b0;
            bits.valid     <= 1'b0;
            bits.soc       <= 1'b0;
            bits.eoc       <= 1'b0;
            bits.seq_error <= 1'b0;
        end else begin
            bits.valid     <= 1'b0;
            bits.soc       <= 1'b0;
            bits.eoc       <= 1'b0;
            bits.seq_error <= 1'b0;
            if (seq_valid) begin
                if (state == RX_FRAME) begin
                    case (seq)
                        SEQ_X: begin
                            // logic 1, release the previous bit
                            bits.valid <= held_valid;
                            prev_bit   <= 1'b1;
                            held_valid <= 1'b1;
                        end
                        SEQ_Z: begin
                            if (prev_bit) begin
                                // Z straight after X is illegal
                                bits.valid     <= 1'b1;
                                bits.seq_error <= 1'b1;
                                state          <= RX_IDLE;
                            end else begin
                                bits.valid <= held_valid;
                                prev_bit   <= 1'b0;
                                held_valid <= 1'b1;
                            end
                        end
                        SEQ_Y: begin
                            if (prev_bit) begin
                                // logic 0 after a 1
                                bits.valid <= held_valid;
                                prev_bit   <= 1'b0;
                                held_valid <= 1'b1;
                            end else begin
                                // Y after a 0 ends the frame, the held 0 is not data
                                bits.valid <= 1'b1;
                                bits.eoc   <= 1'b1;
                                state      <= RX_IDLE;
                            end
                        end
                        default: begin
                            bits.valid     <= 1'b1;
                            bits.seq_error <= 1'b1;
                            state          <= RX_IDLE;
                        end
                    endcase
                end else if (seq == SEQ_Z) begin
                    // start of communication counts as a logic 0
                    bits.valid <= 1'b1;
                    bits.soc   <= 1'b1;
                    state      <= RX_FRAME;
                    prev_bit   <= 1'b0;
                    held_valid <= 1'b0;
                end
            end
        end
    end

    // the bit released on a beat is the value held before that sequence
    always_ff @(posedge clk) begin
        bits.bit_value <= prev_bit;
    end

    // markers only travel on a beat and never share one
    one_marker_per_beat: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bits.soc || bits.eoc || bits.seq_error) |->
            (bits.valid && $onehot0({bits.soc, bits.eoc, bits.seq_error})))
        else $error("bit stream marker outside a beat or more than one marker");

endmodule

//--- hw/frame_byte_assembler.sv
// Frame byte assembler forming stage 3 of the ISO 14443 type A receive path
// gathers data bits lsb first into bytes, checks the odd parity bit
// and turns the bit stream into one-cycle frame events
// last_bit keeps the final received bit until the next frame starts

`timescale 1ns/1ps
`include "iso14443a_params.svh"

module frame_byte_assembler
    import iso14443a_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    bit_stream_if.sink               bits,
    output logic                     soc,
    output logic                     eoc,
    output logic                     data_valid,
    output logic                     sequence_error,
    output logic                     parity_error,
    output logic [`ISO_BYTE_BITS-1:0] data,
    output logic [`ISO_BITCNT_W-1:0] data_bits,
    output logic                     last_bit
);

    // counts data bits 0 to 8 and the ninth position is the parity bit
    localparam int CNT_W = $clog2(`ISO_FRAME_BITS);

    rx_state_t                state;
    logic [`ISO_BYTE_BITS-1:0] shift_q;
    logic [CNT_W-1:0]         bit_cnt;
    logic                     data_beat;
    logic                     byte_full;
    logic                     parity_ok;
    logic [`ISO_BYTE_BITS-1:0] short_data;
    logic [4:0]               flags;

    assign data_beat = bits.valid && !bits.soc && !bits.eoc && !bits.seq_error;
    assign byte_full = (bit_cnt == CNT_W'(`ISO_BYTE_BITS));
    // the byte plus its parity bit hold an odd number of ones
    assign parity_ok = ^{shift_q, bits.bit_value};
    // bits enter at the top, so a short byte is moved down to the low bits
    assign short_data = shift_q >> (CNT_W'(`ISO_BYTE_BITS) - bit_cnt);
    assign flags = {soc, eoc, data_valid, sequence_error, parity_error};

    // ==================================================
    // event generation
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= RX_IDLE;
            bit_cnt        <= '0;
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            sequence_error <= 1'b0;
            parity_error   <= 1'b0;
            data           <= '0;
            data_bits      <= '0;
            last_bit       <= 1'b0;
        end else begin
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            sequence_error <= 1'b0;
            parity_error   <= 1'b0;
            data_bits      <= '0;
            if (bits.valid && bits.soc) begin
                soc     <= 1'b1;
                state   <= RX_FRAME;
                bit_cnt <= '0;
            end else if (bits.valid && state == RX_FRAME) begin
                if (bits.seq_error) begin
                    sequence_error <= 1'b1;
                    state          <= RX_IDLE;
                end else if (bits.eoc) begin
                    eoc   <= 1'b1;
                    state <= RX_IDLE;
                    if (byte_full) begin
                        // eight data bits and no parity bit
                        parity_error <= 1'b1;
                    end else if (bit_cnt != '0) begin
                        data_valid <= 1'b1;
                        data_bits  <= bit_cnt[`ISO_BITCNT_W-1:0];
                        data       <= short_data;
                    end
                end else begin
                    last_bit <= bits.bit_value;
                    if (!byte_full) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (parity_ok) begin
                        data_valid <= 1'b1;
                        data       <= shift_q;
                        bit_cnt    <= '0;
                    end else begin
                        // nothing more is reported until the next start
                        parity_error <= 1'b1;
                        state        <= RX_ERROR;
                    end
                end
            end else if (bits.valid && (bits.eoc || bits.seq_error)) begin
                state <= RX_IDLE;
            end
        end
    end

    // data bits shift in from the msb side because the lsb comes first on air
    always_ff @(posedge clk) begin
        if (data_beat && state == RX_FRAME && !byte_full) begin
            shift_q <= {bits.bit_value, shift_q[`ISO_BYTE_BITS-1:1]};
        end
    end

    // ==================================================
    // output checks
    // ==================================================

    // sequences are at least two samples apart upstream, so no flag repeats
    flags_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (|flags) |=> ((flags & $past(flags)) == '0))
        else $error("frame event flag held for more than one cycle");

    soc_alone: assert property (
        @(posedge clk) disable iff (!rst_n)
        soc |-> !(eoc || data_valid || sequence_error || parity_error))
        else $error("soc together with another event flag");

    short_byte_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_valid && eoc) |-> (data_bits != '0))
        else $error("short byte on eoc with data_bits zero");

    flags_low_in_reset: assert property (
        @(posedge clk)
        !rst_n |=> (flags == '0))
        else $error("event flag high during reset");

endmodule

//--- hw/iso14443a_frame_decode.sv
// ISO 14443 type A frame decoder for the 106 kbit/s receive path
// half-bit pause samples go through the sequence sampler, the Miller bit
// decoder and the byte assembler, which produces one-cycle frame events

`timescale 1ns/1ps
`include "iso14443a_params.svh"

module iso14443a_frame_decode
    import iso14443a_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sample_valid,
    input  logic                     pause,
    output logic                     soc,
    output logic                     eoc,
    output logic [`ISO_BYTE_BITS-1:0] data,
    output logic [`ISO_BITCNT_W-1:0] data_bits,
    output logic                     data_valid,
    output logic                     sequence_error,
    output logic                     parity_error,
    output logic                     last_bit
);

    // sampler to decoder
    logic        seq_valid;
    miller_seq_t seq;

    // decoder to assembler
    bit_stream_if bits_if ();

    miller_sequence_sampler miller_sequence_sampler_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .pause        (pause),
        .seq_valid    (seq_valid),
        .seq          (seq)
    );

    miller_bit_decoder miller_bit_decoder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .seq_valid (seq_valid),
        .seq       (seq),
        .bits      (bits_if.source)
    );

    frame_byte_assembler frame_byte_assembler_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .bits           (bits_if.sink),
        .soc            (soc),
        .eoc            (eoc),
        .data_valid     (data_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error),
        .data           (data),
        .data_bits      (data_bits),
        .last_bit       (last_bit)
    );

endmodule

//--- verification/frame_event_checker.sv
// Frame event checker for the ISO 14443 type A frame decoder testbench
// keeps a queue of expected frame events and compares every DUT event cycle
// against the head of the queue, last_bit is compared on eoc

`timescale 1ns/1ps
`include "iso14443a_params.svh"

module frame_event_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      soc,
    input  logic                      eoc,
    input  logic                      data_valid,
    input  logic                      sequence_error,
    input  logic                      parity_error,
    input  logic [`ISO_BYTE_BITS-1:0] data,
    input  logic [`ISO_BITCNT_W-1:0]  data_bits,
    input  logic                      last_bit,
    output logic                      check_failed
);

    // one entry is {soc, eoc, data_valid, sequence_error, parity_error, data, data_bits, last_bit}
    localparam int EV_W = 5 + `ISO_BYTE_BITS + `ISO_BITCNT_W + 1;

    logic [EV_W-1:0]           exp_q [$];
    logic [4:0]                flags;
    logic [4:0]                exp_flags;
    logic [`ISO_BYTE_BITS-1:0] exp_data;
    logic [`ISO_BITCNT_W-1:0]  exp_bits;
    logic                      exp_last;

    assign flags = {soc, eoc, data_valid, sequence_error, parity_error};

    task automatic push_event(input logic s, input logic e, input logic dv, input logic se,
                              input logic pe, input logic [`ISO_BYTE_BITS-1:0] d,
                              input logic [`ISO_BITCNT_W-1:0] n, input logic lb);
        exp_q.push_back({s, e, dv, se, pe, d, n, lb});
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    initial check_failed = 1'b0;

    // ==================================================
    // event comparison
    // ==================================================
    // outputs move on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n && !check_failed && flags != 5'b0) begin
            assert (exp_q.size() != 0) else begin
                $display("a frame event arrived at %0t when no event was expected", $time);
                check_failed = 1'b1;
            end
            if (exp_q.size() != 0) begin
                {exp_flags, exp_data, exp_bits, exp_last} = exp_q.pop_front();
                assert (flags == exp_flags) else begin
                    $display("[ERROR] flags {soc,eoc,dv,seq_err,par_err} expected %h got %h",
                             exp_flags, flags);
                    check_failed = 1'b1;
                end
                assert (data_bits == exp_bits) else begin
                    $display("[ERROR] data_bits expected %h got %h", exp_bits, data_bits);
                    check_failed = 1'b1;
                end
                // data only carries a byte when data_valid is expected
                if (exp_flags[2]) begin
                    assert (data == exp_data) else begin
                        $display("[ERROR] data expected %h got %h", exp_data, data);
                        check_failed = 1'b1;
                    end
                end
                if (exp_flags[3]) begin
                    assert (last_bit == exp_last) else begin
                        $display("[ERROR] last_bit expected %h got %h", exp_last, last_bit);
                        check_failed = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- verification/frame_decode_tb.sv
// Testbench for the ISO 14443 type A frame decoder
// encodes a table of frames into Miller half-bit samples with random gaps,
// predicts the frame events from the protocol rules and checks them

`timescale 1ns/1ps
`include "iso14443a_params.svh"

module frame_decode_tb
    import iso14443a_pkg::*;
();

    localparam int NUM_ROWS   = 11;
    localparam int IDLE_Y_SEQ = 4;

    // injection kinds of a table row
    localparam int INJ_NONE      = 0;
    localparam int INJ_PARITY    = 1;
    localparam int INJ_Z_AFTER_X = 2;
    localparam int INJ_BAD       = 3;
    localparam int INJ_CUT       = 4;

    logic                      clk;
    logic                      rst_n;
    logic                      sample_valid;
    logic                      pause;
    logic                      soc;
    logic                      eoc;
    logic [`ISO_BYTE_BITS-1:0] data;
    logic [`ISO_BITCNT_W-1:0]  data_bits;
    logic                      data_valid;
    logic                      sequence_error;
    logic                      parity_error;
    logic                      last_bit;
    logic                      check_failed;

    // stimulus table, byte 0 of a frame sits in bits 7:0 of row_bytes
    logic [31:0]               row_bytes  [NUM_ROWS];
    int                        row_nbytes [NUM_ROWS];
    int                        row_short  [NUM_ROWS];
    logic [7:0]                row_tail   [NUM_ROWS];
    int                        row_inject [NUM_ROWS];
    int                        row_pos    [NUM_ROWS];
    int                        row_count;

    // half-sample pairs {first half pause, second half pause} of one row
    logic [1:0]                pair_q [$];
    integer                    seed;
    int                        total_samples;
    int                        timeout_limit;
    int                        cycle_count;

    iso14443a_frame_decode iso14443a_frame_decode_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid   (sample_valid),
        .pause          (pause),
        .soc            (soc),
        .eoc            (eoc),
        .data           (data),
        .data_bits      (data_bits),
        .data_valid     (data_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error),
        .last_bit       (last_bit)
    );

    frame_event_checker event_checker_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .soc            (soc),
        .eoc            (eoc),
        .data_valid     (data_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error),
        .data           (data),
        .data_bits      (data_bits),
        .last_bit       (last_bit),
        .check_failed   (check_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped after a failing check");
    endtask

    // the checker raises check_failed on its first mismatch
    initial begin
        @(posedge check_failed);
        stop_with_failure();
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout, the run went past %0d cycles", timeout_limit);
            stop_with_failure();
        end
    end

    // ==================================================
    // frame encoding and expected events
    // ==================================================

    // odd parity bit, set when the byte holds an even number of ones
    function automatic logic parity_bit(input logic [7:0] b);
        return ~^b;
    endfunction

    // X pauses in the second half, Z in the first, BAD in both, Y in neither
    function automatic logic [1:0] half_pauses(input miller_seq_t s);
        case (s)
            SEQ_X:   return 2'b01;
            SEQ_Z:   return 2'b10;
            SEQ_BAD: return 2'b11;
            default: return 2'b00;
        endcase
    endfunction

    // modified Miller, 1 is X, 0 is Y after a 1 and Z otherwise
    task automatic put_bit(input logic b, inout logic prev);
        if (b) begin
            pair_q.push_back(half_pauses(SEQ_X));
        end else if (prev) begin
            pair_q.push_back(half_pauses(SEQ_Y));
        end else begin
            pair_q.push_back(half_pauses(SEQ_Z));
        end
        prev = b;
    endtask

    task automatic add_row(input logic [31:0] bytes, input int nbytes, input int short_bits,
                           input logic [7:0] tail, input int inject, input int pos);
        row_bytes[row_count]  = bytes;
        row_nbytes[row_count] = nbytes;
        row_short[row_count]  = short_bits;
        row_tail[row_count]   = tail;
        row_inject[row_count] = inject;
        row_pos[row_count]    = pos;
        row_count++;
    endtask

    task automatic build_table();
        row_count = 0;
        add_row(32'h0000_2093, 2, 0, 8'h00, INJ_NONE, 0);
        // 7 bit short frame alone
        add_row(32'h0000_0000, 0, 7, 8'h26, INJ_NONE, 0);
        add_row(32'h0000_7093, 2, 0, 8'h00, INJ_PARITY, 1);
        add_row(32'h0000_0050, 2, 0, 8'h00, INJ_NONE, 0);
        add_row(32'h0000_0052, 1, 0, 8'h00, INJ_Z_AFTER_X, 1);
        add_row(32'h0000_0530, 2, 0, 8'h00, INJ_NONE, 0);
        add_row(32'h0000_0060, 1, 0, 8'h00, INJ_BAD, 0);
        add_row(32'h0000_0000, 0, 7, 8'h52, INJ_NONE, 0);
        add_row(32'h0000_7093, 2, 0, 8'h00, INJ_CUT, 0);
        // full bytes followed by a 3 bit tail
        add_row(32'h0000_2095, 2, 3, 8'h05, INJ_NONE, 0);
        add_row(32'h0000_2093, 2, 0, 8'h00, INJ_NONE, 0);
    endtask

    task automatic encode_row(input int r);
        logic       prev;
        logic [7:0] byte_v;
        int         nfull;
        pair_q.delete();
        prev  = 1'b0;
        nfull = row_nbytes[r];
        if (row_inject[r] == INJ_Z_AFTER_X || row_inject[r] == INJ_BAD) begin
            nfull = row_pos[r];
        end
        // start of communication is a Z seen in idle
        pair_q.push_back(half_pauses(SEQ_Z));
        for (int i = 0; i < nfull; i++) begin
            byte_v = row_bytes[r][`ISO_BYTE_BITS*i +: `ISO_BYTE_BITS];
            for (int k = 0; k < `ISO_BYTE_BITS; k++) begin
                put_bit(byte_v[k], prev);
            end
            if (row_inject[r] == INJ_PARITY && i == row_pos[r]) begin
                put_bit(!parity_bit(byte_v), prev);
            end else if (!(row_inject[r] == INJ_CUT && i == nfull - 1)) begin
                put_bit(parity_bit(byte_v), prev);
            end
        end
        for (int k = 0; k < row_short[r]; k++) begin
            put_bit(row_tail[r][k], prev);
        end
        case (row_inject[r])
            INJ_Z_AFTER_X: begin
                pair_q.push_back(half_pauses(SEQ_X));
                pair_q.push_back(half_pauses(SEQ_Z));
            end
            INJ_BAD: pair_q.push_back(half_pauses(SEQ_BAD));
            default: begin
                // end of communication, a logic 0 then Y
                put_bit(1'b0, prev);
                pair_q.push_back(half_pauses(SEQ_Y));
            end
        endcase
        for (int k = 0; k < IDLE_Y_SEQ; k++) begin
            pair_q.push_back(half_pauses(SEQ_Y));
        end
    endtask

    task automatic expect_row(input int r);
        logic [7:0] byte_v;
        logic [7:0] tail_v;
        int         nfull;
        int         n;
        n     = row_short[r];
        nfull = (row_inject[r] == INJ_NONE) ? row_nbytes[r] : row_pos[r];
        if (row_inject[r] == INJ_CUT) begin
            nfull = row_nbytes[r] - 1;
        end
        event_checker_inst.push_event(1, 0, 0, 0, 0, '0, '0, 0);
        for (int i = 0; i < nfull; i++) begin
            byte_v = row_bytes[r][`ISO_BYTE_BITS*i +: `ISO_BYTE_BITS];
            event_checker_inst.push_event(0, 0, 1, 0, 0, byte_v, '0, 0);
        end
        case (row_inject[r])
            INJ_PARITY: event_checker_inst.push_event(0, 0, 0, 0, 1, '0, '0, 0);
            INJ_Z_AFTER_X, INJ_BAD: event_checker_inst.push_event(0, 0, 0, 1, 0, '0, '0, 0);
            INJ_CUT: begin
                // the last bit on air is data bit 7 of the cut byte
                byte_v = row_bytes[r][`ISO_BYTE_BITS*nfull +: `ISO_BYTE_BITS];
                event_checker_inst.push_event(0, 1, 0, 0, 1, '0, '0, byte_v[7]);
            end
            default: begin
                if (n > 0) begin
                    tail_v = row_tail[r] & ((8'd1 << n) - 8'd1);
                    event_checker_inst.push_event(0, 1, 1, 0, 0, tail_v,
                                                  `ISO_BITCNT_W'(n), row_tail[r][n-1]);
                end else begin
                    byte_v = row_bytes[r][`ISO_BYTE_BITS*(nfull-1) +: `ISO_BYTE_BITS];
                    event_checker_inst.push_event(0, 1, 0, 0, 0, '0, '0, parity_bit(byte_v));
                end
            end
        endcase
    endtask

    // ==================================================
    // sample driver and main sequence
    // ==================================================

    // one half-bit sample after a random gap of 0 to 3 cycles
    task automatic drive_sample(input logic p);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        sample_valid = 1'b1;
        pause        = p;
        @(negedge clk);
        sample_valid = 1'b0;
        pause        = 1'b0;
    endtask

    task automatic check_idle_outputs();
        assert ({soc, eoc, data_valid, sequence_error, parity_error} == 5'b0) else begin
            $display("[ERROR] event flags in reset expected %h got %h", 5'h00,
                     {soc, eoc, data_valid, sequence_error, parity_error});
            stop_with_failure();
        end
        assert (data == '0 && data_bits == '0 && last_bit == 1'b0) else begin
            $display("[ERROR] data, data_bits, last_bit in reset expected 0 got %h %h %h",
                     data, data_bits, last_bit);
            stop_with_failure();
        end
    endtask

    initial begin
        seed          = 32'h9b97;
        rst_n         = 1'b0;
        sample_valid  = 1'b0;
        pause         = 1'b0;
        cycle_count   = 0;
        timeout_limit = 0;
        total_samples = 0;
        build_table();
        for (int r = 0; r < row_count; r++) begin
            encode_row(r);
            total_samples += 2 * pair_q.size();
        end
        // each sample takes at most four cycles with its gap
        timeout_limit = total_samples * 4 + 200;
        repeat (16) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        for (int r = 0; r < row_count; r++) begin
            encode_row(r);
            expect_row(r);
            foreach (pair_q[i]) begin
                drive_sample(pair_q[i][1]);
                drive_sample(pair_q[i][0]);
            end
        end
        repeat (20) @(negedge clk);
        if (event_checker_inst.pending_count() != 0) begin
            $display("%0d expected frame events never appeared",
                     event_checker_inst.pending_count());
            stop_with_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+hw
hw/iso14443a_pkg.sv
hw/bit_stream_if.sv
hw/miller_sequence_sampler.sv
hw/miller_bit_decoder.sv
hw/frame_byte_assembler.sv
hw/iso14443a_frame_decode.sv
verification/frame_event_checker.sv
verification/frame_decode_tb.sv
